// File: rtl/arcade_pkg.sv
// Arcade core shared types
package arcade_pkg;

    // Word address width of the graphics ROM
    localparam int ADDR_W  = 10;

    // Colour channel width
    localparam int COLOR_W = 4;

    // Read request from one bank, held until ack
    typedef struct packed {
        logic              rd;
        logic [ADDR_W-1:0] addr;
    } bank_req_t;

    // Response to one bank
    typedef struct packed {
        logic        ack;   // Request accepted
        logic        rdy;   // Data valid
        logic [15:0] data;
    } bank_rsp_t;

    // Byte lanes of a ROM word
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } byte_pair_t;

    // ROM word, as a halfword or as its two bytes
    typedef union packed {
        logic [15:0] half;
        byte_pair_t  bytes;
    } rom_word_u;

    // Download write towards the memory
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        rom_word_u         data;
        logic [1:0]        mask;  // Bit 0 low byte, bit 1 high byte
    } prog_wr_t;

endpackage

// File: rtl/rom_loader.sv
// ROM download byte packer
`timescale 1ns/1ps

module rom_loader import arcade_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output prog_wr_t    prog
);

    logic              we_q;
    logic [ADDR_W-1:0] addr_q;
    rom_word_u         word_d;
    rom_word_u         word_q;
    logic [1:0]        mask_d;
    logic [1:0]        mask_q;

    // Place the byte in the lane picked by the byte address
    always_comb begin
        word_d.half = '0;
        if (ioctl_addr[0]) begin
            word_d.bytes.hi = ioctl_dout;   // Odd byte
            mask_d          = 2'b10;
        end else begin
            word_d.bytes.lo = ioctl_dout;   // Even byte
            mask_d          = 2'b01;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ioctl_wr;               // One write per download byte
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            addr_q <= ioctl_addr[ADDR_W:1]; // Byte to word address
            word_q <= word_d;
            mask_q <= mask_d;
        end
    end

    assign prog.we   = we_q;
    assign prog.addr = addr_q;
    assign prog.data = word_q;
    assign prog.mask = mask_q;

endmodule

// File: rtl/mem_ctrl.sv
// Graphics ROM memory controller
`timescale 1ns/1ps

module mem_ctrl import arcade_pkg::*; #(
    parameter int RD_LAT = 3
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      prog_en,
    input  prog_wr_t  prog,
    input  bank_req_t ba_req [2],
    output bank_rsp_t ba_rsp [2]
);

    logic [15:0]       mem [2**ADDR_W];
    logic [1:0]        grant;
    logic              sel;
    logic              last;        // Bank served most recently
    logic [ADDR_W-1:0] rd_addr;

    // Read pipeline, one entry per cycle of latency
    logic [RD_LAT-1:0] vld;
    logic [RD_LAT-1:0] tag;
    logic [15:0]       dat [RD_LAT];

    // Round robin between the banks, nothing goes through during download
    always_comb begin
        grant = 2'b00;
        if (!prog_en) begin
            if (ba_req[0].rd && ba_req[1].rd) begin
                grant = last ? 2'b01 : 2'b10;
            end else begin
                grant = {ba_req[1].rd, ba_req[0].rd};
            end
        end
    end

    assign sel     = grant[1];
    assign rd_addr = ba_req[sel].addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last <= 1'b0;
            vld  <= '0;
        end else begin
            if (|grant) begin
                last <= sel;
            end
            vld[0] <= |grant;
            for (int i = 1; i < RD_LAT; i++) begin
                vld[i] <= vld[i-1];
            end
        end
    end

    // Tag and data travel alongside the valid bits
    always_ff @(posedge clk) begin
        tag[0] <= sel;
        dat[0] <= mem[rd_addr];
        for (int i = 1; i < RD_LAT; i++) begin
            tag[i] <= tag[i-1];
            dat[i] <= dat[i-1];
        end
    end

    // Byte masked download writes
    always_ff @(posedge clk) begin
        if (prog.we) begin
            if (prog.mask[0]) begin
                mem[prog.addr][7:0] <= prog.data.bytes.lo;
            end
            if (prog.mask[1]) begin
                mem[prog.addr][15:8] <= prog.data.bytes.hi;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            ba_rsp[b].ack  = grant[b];
            ba_rsp[b].rdy  = vld[RD_LAT-1] && (tag[RD_LAT-1] == b[0]);
            ba_rsp[b].data = dat[RD_LAT-1];   // Shared return bus
        end
    end

endmodule

// File: rtl/video_timing.sv
// Video timing generator
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 16,
    parameter int H_TOTAL  = 40,
    parameter int V_ACTIVE = 4,
    parameter int V_TOTAL  = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic                       pxl_cen,
    output logic [$clog2(H_TOTAL)-1:0] hcnt,
    output logic [$clog2(V_TOTAL)-1:0] vcnt,
    output logic                       LHBL,
    output logic                       LVBL,
    output logic                       HS,
    output logic                       VS
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    logic [HW-1:0] h_nxt;
    logic [VW-1:0] v_nxt;

    // Next position, line advances when the pixel count wraps
    always_comb begin
        h_nxt = hcnt + 1'b1;
        v_nxt = vcnt;
        if (hcnt == HW'(H_TOTAL - 1)) begin
            h_nxt = '0;
            if (vcnt == VW'(V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = vcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
            hcnt    <= '0;
            vcnt    <= '0;
            LHBL    <= 1'b0;
            LVBL    <= 1'b0;
            HS      <= 1'b0;
            VS      <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;            // Half the system clock
            if (pxl_cen) begin
                hcnt <= h_nxt;
                vcnt <= v_nxt;
                // Windows follow the new count so they line up with it
                LHBL <= h_nxt < HW'(H_ACTIVE);
                LVBL <= v_nxt < VW'(V_ACTIVE);
                HS   <= (h_nxt >= HW'(H_ACTIVE + 4)) && (h_nxt < HW'(H_ACTIVE + 8));
                VS   <= v_nxt == VW'(V_ACTIVE + 1);
            end
        end
    end

endmodule

// File: rtl/pattern_fetch.sv
// Line buffered pattern fetcher
`timescale 1ns/1ps

module pattern_fetch import arcade_pkg::*; #(
    parameter int H_ACTIVE = 16,
    parameter int V_ACTIVE = 4,
    parameter int V_TOTAL  = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    input  logic [$clog2(H_ACTIVE)-1:0] hcnt,
    input  logic [$clog2(V_TOTAL)-1:0]  vcnt,
    input  logic                        LHBL,
    input  logic                        LVBL,
    output bank_req_t                   ba_req,
    input  bank_rsp_t                   ba_rsp,
    output logic [COLOR_W-1:0]          pixel
);

    localparam int WORDS = H_ACTIVE / 4;        // Four pixels per word
    localparam int IDX_W = $clog2(WORDS + 1);
    localparam int BW    = $clog2(WORDS);       // Line buffer index
    localparam int VW    = $clog2(V_TOTAL);
    localparam int PW    = $clog2(H_ACTIVE);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        SWAP
    } state_t;

    state_t            state;
    logic              lhbl_l;          // LHBL of the previous pixel slot
    logic [VW-1:0]     next_line;
    logic              start;
    logic [ADDR_W-1:0] base;
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic [15:0]       line_buf [WORDS];
    logic [15:0]       disp_buf [WORDS];
    logic [15:0]       disp_word;

    assign next_line = (vcnt == VW'(V_TOTAL - 1)) ? '0 : vcnt + 1'b1;

    // Blank has just begun and the coming line is visible
    assign start = pxl_cen && lhbl_l && !LHBL && (next_line < VW'(V_ACTIVE));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            lhbl_l <= 1'b0;
            rd_idx <= '0;
            wr_idx <= '0;
        end else begin
            if (pxl_cen) begin
                lhbl_l <= LHBL;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        state  <= FETCH;
                        rd_idx <= '0;
                        wr_idx <= '0;
                    end
                end
                FETCH: begin
                    if (ba_rsp.ack) begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                    if (ba_rsp.rdy) begin
                        wr_idx <= wr_idx + 1'b1;
                        if (wr_idx == IDX_W'(WORDS - 1)) begin
                            state <= SWAP;  // Last word is in
                        end
                    end
                end
                SWAP:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            base <= ADDR_W'(next_line) * ADDR_W'(WORDS);
        end
        if (state == FETCH && ba_rsp.rdy) begin
            line_buf[wr_idx[BW-1:0]] <= ba_rsp.data;
        end
        if (state == SWAP) begin
            disp_buf <= line_buf;           // Ready before the line starts
        end
    end

    // Requests go out back to back, several can be in flight
    assign ba_req.rd   = (state == FETCH) && (rd_idx < IDX_W'(WORDS));
    assign ba_req.addr = base + ADDR_W'(rd_idx);

    assign disp_word = disp_buf[hcnt[PW-1:2]];

    // Least significant nibble is shown first
    always_comb begin
        pixel = '0;
        if (LHBL && LVBL) begin
            pixel = disp_word[{hcnt[1:0], 2'b00} +: COLOR_W];
        end
    end

endmodule

// File: rtl/game_top.sv
// Arcade game core top level
`timescale 1ns/1ps

module game_top import arcade_pkg::*; #(
    parameter int H_ACTIVE = 16,
    parameter int H_TOTAL  = 40,
    parameter int V_ACTIVE = 4,
    parameter int V_TOTAL  = 8,
    parameter int RD_LAT   = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               prog_en,
    input  logic [15:0]        ioctl_addr,
    input  logic [7:0]         ioctl_dout,
    input  logic               ioctl_wr,
    input  bank_req_t          host_req,
    output bank_rsp_t          host_rsp,
    output logic               pxl_cen,
    output logic [COLOR_W-1:0] red,
    output logic [COLOR_W-1:0] green,
    output logic [COLOR_W-1:0] blue,
    output logic               LHBL,
    output logic               LVBL,
    output logic               HS,
    output logic               VS
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);
    localparam int PW = $clog2(H_ACTIVE);

    prog_wr_t           prog;
    bank_req_t          ba_req [2];
    bank_rsp_t          ba_rsp [2];
    bank_req_t          fetch_req;
    bank_rsp_t          fetch_rsp;
    logic [HW-1:0]      hcnt;
    logic [VW-1:0]      vcnt;
    logic [COLOR_W-1:0] pixel;

    // Bank 0 feeds the video, bank 1 is the host port
    assign ba_req[0] = fetch_req;
    assign ba_req[1] = host_req;
    assign fetch_rsp = ba_rsp[0];
    assign host_rsp  = ba_rsp[1];

    rom_loader u_loader (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .ioctl_wr   ( ioctl_wr   ),
        .prog       ( prog       )
    );

    mem_ctrl #(
        .RD_LAT ( RD_LAT )
    ) u_mem (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .prog_en ( prog_en ),
        .prog    ( prog    ),
        .ba_req  ( ba_req  ),
        .ba_rsp  ( ba_rsp  )
    );

    video_timing #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_timing (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .hcnt    ( hcnt    ),
        .vcnt    ( vcnt    ),
        .LHBL    ( LHBL    ),
        .LVBL    ( LVBL    ),
        .HS      ( HS      ),
        .VS      ( VS      )
    );

    // Fetcher only needs the pixel index within the active part
    pattern_fetch #(
        .H_ACTIVE ( H_ACTIVE ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_fetch (
        .clk     ( clk          ),
        .rst_n   ( rst_n        ),
        .pxl_cen ( pxl_cen      ),
        .hcnt    ( hcnt[PW-1:0] ),
        .vcnt    ( vcnt         ),
        .LHBL    ( LHBL         ),
        .LVBL    ( LVBL         ),
        .ba_req  ( fetch_req    ),
        .ba_rsp  ( fetch_rsp    ),
        .pixel   ( pixel        )
    );

    // Grayscale output
    assign red   = pixel;
    assign green = pixel;
    assign blue  = pixel;

endmodule

// File: dv/game_tb.sv
// Arcade core testbench
`timescale 1ns/1ps

module game_tb import arcade_pkg::*; ;

    localparam int H_ACTIVE   = 16;
    localparam int H_TOTAL    = 40;
    localparam int V_ACTIVE   = 4;
    localparam int V_TOTAL    = 8;
    localparam int RD_LAT     = 3;
    localparam int CLK_PERIOD = 4;
    localparam int FRAME      = H_TOTAL * V_TOTAL * 2;     // Clocks per frame
    localparam int DL_BYTES   = 32;
    localparam int NUM_READS  = 20;
    localparam int WD_CYCLES  = 2 * DL_BYTES + 3 * FRAME + NUM_READS * 20;

    logic               clk;
    logic               rst_n;
    logic               prog_en;
    logic [15:0]        ioctl_addr;
    logic [7:0]         ioctl_dout;
    logic               ioctl_wr;
    bank_req_t          host_req;
    bank_rsp_t          host_rsp;
    logic               pxl_cen;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
    logic               LHBL;
    logic               LVBL;
    logic               HS;
    logic               VS;

    integer            seed = 32'h40267caa;
    logic [7:0]        ref_mem [DL_BYTES];   // Byte level reference
    logic              dl_done = 1'b0;
    logic [ADDR_W-1:0] ack_addr [$];
    int                ack_cyc [$];
    int                cyc = 0;
    logic [ADDR_W-1:0] exp_addr;
    int                exp_cyc;

    // Video checker state
    logic rst_q  = 1'b0;
    logic pcen_q = 1'b0;
    logic lhbl_q = 1'b0;
    logic lvbl_q = 1'b0;
    logic hs_q   = 1'b0;
    logic vs_q   = 1'b0;
    logic vbl_seen = 1'b0;
    logic armed  = 1'b0;
    int   pix_n  = 0;
    int   line_n = 0;
    int   hs_cnt = 0;
    int   vs_cnt = 0;

    game_top #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .RD_LAT   ( RD_LAT   )
    ) game_top_i (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .prog_en    ( prog_en    ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .ioctl_wr   ( ioctl_wr   ),
        .host_req   ( host_req   ),
        .host_rsp   ( host_rsp   ),
        .pxl_cen    ( pxl_cen    ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .LHBL       ( LHBL       ),
        .LVBL       ( LVBL       ),
        .HS         ( HS         ),
        .VS         ( VS         )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // Even byte sits in the low half
    function automatic logic [15:0] ref_word(input logic [ADDR_W-1:0] a);
        return {ref_mem[2 * a + 1], ref_mem[2 * a]};
    endfunction

    function automatic logic [COLOR_W-1:0] expected_pixel(input int v, input int k);
        logic [15:0] w;
        w = ref_word(ADDR_W'(v * (H_ACTIVE / 4) + k / 4));
        return w[(k % 4) * 4 +: 4];
    endfunction

    task automatic download_byte(input int a);
        logic [7:0] b;
        b = 8'($random(seed));
        ref_mem[a] = b;
        @(posedge clk);
        ioctl_wr   <= 1'b1;
        ioctl_addr <= 16'(a);
        ioctl_dout <= b;
    endtask

    task automatic wait_ack(input int limit);
        int n;
        n = 0;
        @(posedge clk);
        while (!host_rsp.ack) begin
            n++;
            if (n > limit) begin
                $display("Host read request was never acknowledged");
                stop_on_error();
            end
            @(posedge clk);
        end
        host_req.rd <= 1'b0;
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        host_req.rd   <= 1'b1;
        host_req.addr <= a;
        wait_ack(40);
    endtask

    // Host port handshake, latency and data
    always @(posedge clk) begin
        cyc++;
        if (rst_n) begin
            if (host_rsp.rdy) begin
                if (ack_cyc.size() == 0) begin
                    $display("Host rdy pulse without an outstanding read");
                    stop_on_error();
                end else begin
                    exp_addr = ack_addr.pop_front();
                    exp_cyc  = ack_cyc.pop_front();
                    assert (cyc - exp_cyc == RD_LAT) else begin
                        $display("Mismatch host read latency: got %h, expected %h",
                                 cyc - exp_cyc, RD_LAT);
                        stop_on_error();
                    end
                    assert (host_rsp.data == ref_word(exp_addr)) else begin
                        $display("Mismatch host_rsp.data: got %h, expected %h (addr %h)",
                                 host_rsp.data, ref_word(exp_addr), exp_addr);
                        stop_on_error();
                    end
                end
            end
            if (host_rsp.ack) begin
                assert (host_req.rd) else begin
                    $display("Host ack while no read was requested");
                    stop_on_error();
                end
                assert (!prog_en) else begin
                    $display("Host ack during ROM download");
                    stop_on_error();
                end
                ack_addr.push_back(host_req.addr);
                ack_cyc.push_back(cyc);
            end
        end
    end

    // Reset state, video timing and pixels
    always @(posedge clk) begin
        if (!rst_n || !rst_q) begin
            assert (!host_rsp.ack && !host_rsp.rdy && !pxl_cen && !HS && !VS
                    && !LHBL && !LVBL) else begin
                $display("Outputs not low during or right after reset");
                stop_on_error();
            end
        end else begin
            assert (pxl_cen != pcen_q) else begin
                $display("Mismatch pxl_cen: got %h, expected %h", pxl_cen, !pcen_q);
                stop_on_error();
            end
            assert (red == green && green == blue) else begin
                $display("Mismatch green/blue: red %h green %h blue %h", red, green, blue);
                stop_on_error();
            end
            if (LHBL && LVBL) begin
                if (armed) begin
                    assert (red == expected_pixel(line_n, pix_n)) else begin
                        $display("Mismatch red: got %h, expected %h", red,
                                 expected_pixel(line_n, pix_n));
                        stop_on_error();
                    end
                end
            end else begin
                assert (red == '0) else begin
                    $display("Mismatch red: got %h, expected %h in blank", red, 4'h0);
                    stop_on_error();
                end
            end
            if (lhbl_q && !LHBL) begin
                if (armed) begin
                    assert (pix_n == H_ACTIVE) else begin
                        $display("Mismatch LHBL slots: got %h, expected %h", pix_n, H_ACTIVE);
                        stop_on_error();
                    end
                end
                if (LVBL) line_n++;
            end
            if (lvbl_q && !LVBL) begin
                if (armed) begin
                    assert (line_n == V_ACTIVE) else begin
                        $display("Mismatch LVBL lines: got %h, expected %h", line_n, V_ACTIVE);
                        stop_on_error();
                    end
                end
                if (dl_done) vbl_seen = 1'b1;  // Line 0 is fetched in this blank
            end
            if (!LVBL) line_n = 0;
            if (!lhbl_q && LHBL) begin
                if (armed) begin
                    assert (hs_cnt == 1) else begin
                        $display("Mismatch HS pulses per line: got %h, expected %h", hs_cnt, 1);
                        stop_on_error();
                    end
                end
                hs_cnt = 0;
            end
            if (!lvbl_q && LVBL) begin
                if (armed) begin
                    assert (vs_cnt == 1) else begin
                        $display("Mismatch VS pulses per frame: got %h, expected %h", vs_cnt, 1);
                        stop_on_error();
                    end
                end
                vs_cnt = 0;
                armed  = vbl_seen;
            end
            if (HS && !hs_q) hs_cnt++;
            if (VS && !vs_q) vs_cnt++;
            if (!LHBL) pix_n = 0;
            else if (pxl_cen) pix_n++;  // Slot ends on this edge
        end
        rst_q  = rst_n;
        pcen_q = pxl_cen;
        lhbl_q = LHBL;
        lvbl_q = LVBL;
        hs_q   = HS;
        vs_q   = VS;
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, the run did not finish in time");
        stop_on_error();
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        prog_en    = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr   = 1'b0;
        host_req   = '0;
        repeat (5) @(posedge clk);
        rst_n   <= 1'b1;
        prog_en <= 1'b1;

        for (int i = 0; i < DL_BYTES; i++) begin
            download_byte(i);
        end
        @(posedge clk);
        ioctl_wr <= 1'b0;

        // Request held across the end of the download
        host_req.rd   <= 1'b1;
        host_req.addr <= ADDR_W'(5);
        repeat (10) @(posedge clk);
        prog_en <= 1'b0;
        dl_done <= 1'b1;
        wait_ack(20);

        repeat (2 * FRAME) @(posedge clk);

        for (int r = 0; r < NUM_READS; r++) begin
            repeat ($unsigned($random(seed)) % 16) @(posedge clk);
            host_read(ADDR_W'($unsigned($random(seed)) % 16));
        end
        repeat (20) @(posedge clk);

        if (ack_cyc.size() != 0 || !armed) begin
            $display("Reads left outstanding or video checks never started");
            stop_on_error();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: flist.f
rtl/arcade_pkg.sv
rtl/rom_loader.sv
rtl/mem_ctrl.sv
rtl/video_timing.sv
rtl/pattern_fetch.sv
rtl/game_top.sv
dv/game_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= game_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD_DIR)
